// ==== hdl/issue_pkg.sv ====
// Shared widths, types and the ROB age compare for the issue stage.
// ROB ids wrap modulo 2**ROB_AW; rob_older is only meaningful while all
// in-flight ids lie within a window of 15 from the oldest one.
// Opcode value zero is the "unused" encoding in each enum.

package issue_pkg;

   localparam int PRF_AW = 6;                // 64 physical registers
   localparam int ROB_AW = 5;                // 32 ROB ids

   typedef logic [PRF_AW-1:0] preg_t;        // Physical register number
   typedef logic [ROB_AW-1:0] rob_id_t;      // ROB id

   typedef enum logic [3:0]
   {
      ALU_ADD = 4'd0,
      ALU_SUB = 4'd1,
      ALU_AND = 4'd2,
      ALU_OR  = 4'd3,
      ALU_XOR = 4'd4,
      ALU_SLL = 4'd5,
      ALU_SRL = 4'd6,
      ALU_SRA = 4'd7,
      ALU_SLT = 4'd8
   } alu_opc_e;

   typedef enum logic [2:0]
   {
      LSU_LB = 3'd0,
      LSU_LH = 3'd1,
      LSU_LW = 3'd2,
      LSU_SB = 3'd3,
      LSU_SH = 3'd4,
      LSU_SW = 3'd5
   } lsu_opc_e;

   typedef struct packed {
      alu_opc_e    opc;                      // ALU operation
      logic [31:0] imm;                      // Full immediate
   } alu_uop_t;                              // 36 bits

   typedef struct packed {
      lsu_opc_e    opc;                      // Memory operation
      logic [11:0] off;                      // Signed address offset
   } lsu_uop_t;                              // 15 bits

   // True when a was allocated before b, given the in-flight window
   function automatic logic rob_older(input rob_id_t a, input rob_id_t b);
      rob_id_t diff;
      diff = b - a;                          // Wraps modulo 2**ROB_AW
      return (diff != '0) && !diff[ROB_AW-1]; // Distance 1..15
   endfunction

endpackage

// ==== hdl/rs_issue_if.sv ====
// Candidate op from one reservation station to the issue selector.
// A transfer happens in a cycle where valid and take are both high.
// take may depend on valid; valid must not depend on take.

`timescale 1ns/1ns

interface rs_issue_if
   import issue_pkg::*;
#(
   parameter type payload_t = alu_uop_t
)
();

   logic     valid;                          // Station offers an op
   rob_id_t  rob_id;                         // Age of the offered op
   preg_t    prs1;
   logic     prs1_re;
   preg_t    prs2;
   logic     prs2_re;
   preg_t    prd;
   logic     prd_we;
   payload_t payload;                        // Unit specific part
   logic     take;                           // Selector accepts the op

   modport rs  (output valid, rob_id, prs1, prs1_re, prs2, prs2_re, prd, prd_we,
                payload, input take);
   modport sel (input valid, rob_id, prs1, prs1_re, prs2, prs2_re, prd, prd_we,
                payload, output take);

endinterface

// ==== hdl/issue_rs.sv ====
// Reservation station with a typed payload, RS_DEPTH entries (2 or more).
// ready reflects only the stored state, so a full station refuses a push
// even in the cycle an entry leaves. The offered op is the oldest entry
// whose read-enabled sources are clear in busytable, combinational.

`timescale 1ns/1ns

module issue_rs
   import issue_pkg::*;
#(
   parameter type payload_t = alu_uop_t,
   parameter int  RS_DEPTH  = 4
)
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    push,
   output logic                    ready,
   input  payload_t                push_payload,
   input  preg_t                   push_prs1,
   input  logic                    push_prs1_re,
   input  preg_t                   push_prs2,
   input  logic                    push_prs2_re,
   input  preg_t                   push_prd,
   input  logic                    push_prd_we,
   input  rob_id_t                 push_rob_id,
   input  logic [(1<<PRF_AW)-1:0]  busytable,
   rs_issue_if.rs                  cand
);

   localparam int IW = $clog2(RS_DEPTH);

   typedef struct packed {
      rob_id_t  rob_id;
      preg_t    prs1;
      logic     prs1_re;
      preg_t    prs2;
      logic     prs2_re;
      preg_t    prd;
      logic     prd_we;
      payload_t payload;
   } ent_t;

   logic [RS_DEPTH-1:0] ent_vld;             // Slot occupied
   ent_t                ent [RS_DEPTH];      // Slot contents
   logic [RS_DEPTH-1:0] ent_rdy;             // Occupied and sources clear
   ent_t                push_ent;
   logic [IW-1:0]       free_idx;            // Lowest free slot
   logic [IW-1:0]       pick_idx;            // Oldest ready slot
   logic                pick_any;

   assign ready = ~&ent_vld;                 // Any slot free

   assign push_ent = '{rob_id:  push_rob_id,
                       prs1:    push_prs1,
                       prs1_re: push_prs1_re,
                       prs2:    push_prs2,
                       prs2_re: push_prs2_re,
                       prd:     push_prd,
                       prd_we:  push_prd_we,
                       payload: push_payload};

   // Scan downward so the lowest free index wins
   always_comb
   begin
      free_idx = '0;
      for (int i = RS_DEPTH - 1; i >= 0; i--)
         if (!ent_vld[i])
            free_idx = IW'(i);
   end

   always_comb
   begin
      for (int i = 0; i < RS_DEPTH; i++)
         ent_rdy[i] = ent_vld[i]
                    & (~ent[i].prs1_re | ~busytable[ent[i].prs1])  // Src 1 clear
                    & (~ent[i].prs2_re | ~busytable[ent[i].prs2]); // Src 2 clear
   end

   // Oldest-first among ready slots
   always_comb
   begin
      pick_any = 1'b0;
      pick_idx = '0;
      for (int i = 0; i < RS_DEPTH; i++)
         if (ent_rdy[i] && (!pick_any || rob_older(ent[i].rob_id, ent[pick_idx].rob_id)))
         begin
            pick_any = 1'b1;
            pick_idx = IW'(i);
         end
   end

   assign cand.valid   = pick_any;
   assign cand.rob_id  = ent[pick_idx].rob_id;
   assign cand.prs1    = ent[pick_idx].prs1;
   assign cand.prs1_re = ent[pick_idx].prs1_re;
   assign cand.prs2    = ent[pick_idx].prs2;
   assign cand.prs2_re = ent[pick_idx].prs2_re;
   assign cand.prd     = ent[pick_idx].prd;
   assign cand.prd_we  = ent[pick_idx].prd_we;
   assign cand.payload = ent[pick_idx].payload;

   // Push and take never hit the same slot
   always_ff @(posedge clk)
   begin
      if (rst)
         ent_vld <= '0;
      else
      begin
         if (pick_any && cand.take)
            ent_vld[pick_idx] <= 1'b0;       // Entry leaves
         if (push && ready)
            ent_vld[free_idx] <= 1'b1;       // Entry arrives
      end
   end

   always_ff @(posedge clk)
   begin
      if (push && ready)
         ent[free_idx] <= push_ent;
   end

endmodule

// ==== hdl/issue_select.sv ====
// Merges the ALU and LSU station candidates onto one execute port.
// The older ROB id wins when both offer. One output register holds the
// winner; it reloads only when empty or drained, so every ex_ output is
// stable while ex_valid is high and ex_ready is low.

`timescale 1ns/1ns

module issue_select
   import issue_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   rs_issue_if.sel     alu_cand,
   rs_issue_if.sel     lsu_cand,
   output logic        ex_valid,
   input  logic        ex_ready,
   output logic        ex_unit,              // 0 ALU, 1 LSU
   output alu_opc_e    ex_alu_opc,
   output lsu_opc_e    ex_lsu_opc,
   output logic [31:0] ex_imm,
   output preg_t       ex_prs1,
   output logic        ex_prs1_re,
   output preg_t       ex_prs2,
   output logic        ex_prs2_re,
   output preg_t       ex_prd,
   output logic        ex_prd_we,
   output rob_id_t     ex_rob_id
);

   logic load;                               // Output register can accept
   logic pick_lsu;                           // LSU candidate wins

   assign load     = ~ex_valid | ex_ready;
   assign pick_lsu = lsu_cand.valid
                   & (~alu_cand.valid | rob_older(lsu_cand.rob_id, alu_cand.rob_id));

   assign alu_cand.take = load & alu_cand.valid & ~pick_lsu;
   assign lsu_cand.take = load & pick_lsu;

   always_ff @(posedge clk)
   begin
      if (rst)
         ex_valid <= 1'b0;
      else if (load)
         ex_valid <= alu_cand.valid | lsu_cand.valid;
   end

   // Payload register, loaded only with a real winner
   always_ff @(posedge clk)
   begin
      if (load && pick_lsu)
      begin
         ex_unit    <= 1'b1;
         ex_alu_opc <= alu_opc_e'('0);       // Unused field
         ex_lsu_opc <= lsu_cand.payload.opc;
         ex_imm     <= {{20{lsu_cand.payload.off[11]}}, lsu_cand.payload.off};
         ex_prs1    <= lsu_cand.prs1;
         ex_prs1_re <= lsu_cand.prs1_re;
         ex_prs2    <= lsu_cand.prs2;
         ex_prs2_re <= lsu_cand.prs2_re;
         ex_prd     <= lsu_cand.prd;
         ex_prd_we  <= lsu_cand.prd_we;
         ex_rob_id  <= lsu_cand.rob_id;
      end
      else if (load && alu_cand.valid)
      begin
         ex_unit    <= 1'b0;
         ex_alu_opc <= alu_cand.payload.opc;
         ex_lsu_opc <= lsu_opc_e'('0);       // Unused field
         ex_imm     <= alu_cand.payload.imm;
         ex_prs1    <= alu_cand.prs1;
         ex_prs1_re <= alu_cand.prs1_re;
         ex_prs2    <= alu_cand.prs2;
         ex_prs2_re <= alu_cand.prs2_re;
         ex_prd     <= alu_cand.prd;
         ex_prd_we  <= alu_cand.prd_we;
         ex_rob_id  <= alu_cand.rob_id;
      end
   end

endmodule

// ==== hdl/issue_stage.sv ====
// Issue stage top: ALU and LSU reservation stations feeding one execute port.
// busytable and ROB ids are owned by rename and the ROB outside this block.
// A push at edge N into an idle stage with free sources shows ex_valid after
// edge N+1; flush and operand read are not handled here.

`timescale 1ns/1ns

module issue_stage
   import issue_pkg::*;
#(
   parameter int RS_DEPTH = 4
)
(
   input  logic                   clk,
   input  logic                   rst,
   // ALU lane from rename
   input  logic                   alu_push,
   output logic                   alu_ready,
   input  alu_opc_e               alu_opc,
   input  logic [31:0]            alu_imm,
   input  preg_t                  alu_prs1,
   input  logic                   alu_prs1_re,
   input  preg_t                  alu_prs2,
   input  logic                   alu_prs2_re,
   input  preg_t                  alu_prd,
   input  logic                   alu_prd_we,
   input  rob_id_t                alu_rob_id,
   // LSU lane from rename
   input  logic                   lsu_push,
   output logic                   lsu_ready,
   input  lsu_opc_e               lsu_opc,
   input  logic [11:0]            lsu_imm,
   input  preg_t                  lsu_prs1,
   input  logic                   lsu_prs1_re,
   input  preg_t                  lsu_prs2,
   input  logic                   lsu_prs2_re,
   input  preg_t                  lsu_prd,
   input  logic                   lsu_prd_we,
   input  rob_id_t                lsu_rob_id,
   input  logic [(1<<PRF_AW)-1:0] busytable,  // Set bit means busy
   // To execute
   output logic                   ex_valid,
   input  logic                   ex_ready,
   output logic                   ex_unit,
   output alu_opc_e               ex_alu_opc,
   output lsu_opc_e               ex_lsu_opc,
   output logic [31:0]            ex_imm,
   output preg_t                  ex_prs1,
   output logic                   ex_prs1_re,
   output preg_t                  ex_prs2,
   output logic                   ex_prs2_re,
   output preg_t                  ex_prd,
   output logic                   ex_prd_we,
   output rob_id_t                ex_rob_id
);

   alu_uop_t alu_payload;
   lsu_uop_t lsu_payload;

   assign alu_payload = '{opc: alu_opc, imm: alu_imm};
   assign lsu_payload = '{opc: lsu_opc, off: lsu_imm};

   rs_issue_if #(.payload_t(alu_uop_t)) alu_if ();
   rs_issue_if #(.payload_t(lsu_uop_t)) lsu_if ();

   issue_rs #(.payload_t(alu_uop_t), .RS_DEPTH(RS_DEPTH)) i_alu_rs
   (
      .clk(clk), .rst(rst), .push(alu_push), .ready(alu_ready),
      .push_payload(alu_payload),
      .push_prs1(alu_prs1), .push_prs1_re(alu_prs1_re),
      .push_prs2(alu_prs2), .push_prs2_re(alu_prs2_re),
      .push_prd(alu_prd), .push_prd_we(alu_prd_we),
      .push_rob_id(alu_rob_id), .busytable(busytable), .cand(alu_if)
   );

   issue_rs #(.payload_t(lsu_uop_t), .RS_DEPTH(RS_DEPTH)) i_lsu_rs
   (
      .clk(clk), .rst(rst), .push(lsu_push), .ready(lsu_ready),
      .push_payload(lsu_payload),
      .push_prs1(lsu_prs1), .push_prs1_re(lsu_prs1_re),
      .push_prs2(lsu_prs2), .push_prs2_re(lsu_prs2_re),
      .push_prd(lsu_prd), .push_prd_we(lsu_prd_we),
      .push_rob_id(lsu_rob_id), .busytable(busytable), .cand(lsu_if)
   );

   issue_select i_select
   (
      .clk(clk), .rst(rst), .alu_cand(alu_if), .lsu_cand(lsu_if),
      .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_unit(ex_unit),
      .ex_alu_opc(ex_alu_opc), .ex_lsu_opc(ex_lsu_opc), .ex_imm(ex_imm),
      .ex_prs1(ex_prs1), .ex_prs1_re(ex_prs1_re),
      .ex_prs2(ex_prs2), .ex_prs2_re(ex_prs2_re),
      .ex_prd(ex_prd), .ex_prd_we(ex_prd_we), .ex_rob_id(ex_rob_id)
   );

endmodule

// ==== bench/issue_stage_assertions.sv ====
// Concurrent checks on the issue stage ports, bound into issue_stage.
// Source checks use the busy table of the cycle in which the op was selected.

`timescale 1ns/1ns

module issue_stage_assertions
   import issue_pkg::*;
(
   input logic        clk,
   input logic        rst,
   input logic        alu_ready,
   input logic        lsu_ready,
   input logic [63:0] busytable,
   input logic        ex_valid,
   input logic        ex_ready,
   input logic        ex_unit,
   input alu_opc_e    ex_alu_opc,
   input lsu_opc_e    ex_lsu_opc,
   input logic [31:0] ex_imm,
   input preg_t       ex_prs1,
   input logic        ex_prs1_re,
   input preg_t       ex_prs2,
   input logic        ex_prs2_re,
   input preg_t       ex_prd,
   input logic        ex_prd_we,
   input rob_id_t     ex_rob_id
);

   int          fail_cnt = 0;
   logic [63:0] busy_q;                     // Busy table seen by the last select
   logic        load_q;                     // Output register loaded last edge

   always_ff @(posedge clk)
   begin
      busy_q <= busytable;
      load_q <= !ex_valid || ex_ready;
   end

   a_reset_state: assert property (@(posedge clk) rst |=> !ex_valid && alu_ready && lsu_ready)
   else
   begin
      fail_cnt++;
      $error("After reset ex_valid is set or a lane is not ready");
   end

   // A freshly loaded op had no busy read-enabled source when selected
   a_src_clear: assert property (@(posedge clk) disable iff (rst)
      load_q && ex_valid |-> !(ex_prs1_re && busy_q[ex_prs1]) && !(ex_prs2_re && busy_q[ex_prs2]))
   else
   begin
      fail_cnt++;
      $error("Op with ROB id %0d issued while a source was busy", ex_rob_id);
   end

   a_hold: assert property (@(posedge clk) disable iff (rst)
      ex_valid && !ex_ready |=> $stable({ex_valid, ex_unit, ex_alu_opc, ex_lsu_opc, ex_imm,
         ex_prs1, ex_prs1_re, ex_prs2, ex_prs2_re, ex_prd, ex_prd_we, ex_rob_id}))
   else
   begin
      fail_cnt++;
      $error("Execute outputs changed while stalled");
   end

endmodule

// ==== bench/issue_stage_tb.sv ====
// Testbench for the issue stage: directed tests for reset, busy sources,
// back-pressure and age order, then a random stream with seed 71.
// Immediate assertions here and the bound concurrent ones do the checking.
// Ops are keyed by ROB id, so in-flight ids must stay unique.

`timescale 1ns/1ns

module issue_stage_tb
   import issue_pkg::*;
();

   localparam int RS_DEPTH = 4;
   localparam int TMO      = 100;           // Cycles allowed per wait

   logic        clk = 1'b0;
   logic        rst;
   logic        alu_push;
   logic        alu_ready;
   alu_opc_e    alu_opc;
   logic [31:0] alu_imm;
   preg_t       alu_prs1;
   logic        alu_prs1_re;
   preg_t       alu_prs2;
   logic        alu_prs2_re;
   preg_t       alu_prd;
   logic        alu_prd_we;
   rob_id_t     alu_rob_id;
   logic        lsu_push;
   logic        lsu_ready;
   lsu_opc_e    lsu_opc;
   logic [11:0] lsu_imm;
   preg_t       lsu_prs1;
   logic        lsu_prs1_re;
   preg_t       lsu_prs2;
   logic        lsu_prs2_re;
   preg_t       lsu_prd;
   logic        lsu_prd_we;
   rob_id_t     lsu_rob_id;
   logic [63:0] busytable;
   logic        ex_valid;
   logic        ex_ready;
   logic        ex_unit;
   alu_opc_e    ex_alu_opc;
   lsu_opc_e    ex_lsu_opc;
   logic [31:0] ex_imm;
   preg_t       ex_prs1;
   logic        ex_prs1_re;
   preg_t       ex_prs2;
   logic        ex_prs2_re;
   preg_t       ex_prd;
   logic        ex_prd_we;
   rob_id_t     ex_rob_id;

   integer      seed = 71;
   logic [60:0] sb [int];                   // Pushed ops not yet issued
   rob_id_t     issued [$];                 // ROB ids in issue order
   logic [60:0] obs;
   logic [31:0] rnd;
   rob_id_t     next_rob;
   rob_id_t     old_id;
   rob_id_t     young_id;
   int          pushed;
   int          errors;
   int          last_err;
   int          passed;
   int          failed;
   int          n;
   bit          aborted;

   issue_stage #(.RS_DEPTH(RS_DEPTH)) i_issue_stage (.*);

   bind issue_stage issue_stage_assertions i_assertions (.*);

   always #2 clk = ~clk;                    // 4 ns period

   // Scoreboard samples before the DUT registers update
   always @(posedge clk)
   begin
      if (!rst && ex_valid && ex_ready)
      begin
         obs = {ex_unit, ex_alu_opc, ex_lsu_opc, ex_imm, ex_prs1, ex_prs1_re,
                ex_prs2, ex_prs2_re, ex_prd, ex_prd_we};
         if (!sb.exists(int'(ex_rob_id)))
         begin
            $display("Op with ROB id %0d issued at %0t but was never accepted or issued twice",
                     ex_rob_id, $time);
            errors++;
         end
         else
         begin
            assert (obs == sb[int'(ex_rob_id)])
            else
            begin
               $display("Fail %0t: ROB id %0d issued as %h, pushed as %h", $time, ex_rob_id,
                        obs, sb[int'(ex_rob_id)]);
               errors++;
            end
            sb.delete(int'(ex_rob_id));
         end
         issued.push_back(ex_rob_id);
      end
   end

   task automatic give_up(input string what);
      $display("Timeout at %0t: no %s within %0d cycles", $time, what, TMO);
      errors++;
      aborted = 1'b1;                       // Later waits return at once
   endtask

   // Called and returns at a falling edge; counted ops go to the scoreboard
   task automatic push_op(input logic unit, input rob_id_t rob, input preg_t s1,
                          input logic re1, input preg_t s2, input logic re2,
                          input logic counted);
      int          t;
      logic [31:0] r;
      t = 0;
      while (counted && !aborted && !(unit ? lsu_ready : alu_ready))
      begin
         busytable = '0;                    // Let a full station drain
         ex_ready  = 1'b1;
         t++;
         if (t > TMO)
            give_up("free station slot");
         @(negedge clk);
      end
      r = $random(seed);
      alu_opc = alu_opc_e'(4'(r[3:0] % 9));
      alu_imm = $random(seed);
      lsu_opc = lsu_opc_e'(3'(r[6:4] % 6));
      lsu_imm = r[31:20];
      {alu_prs1, alu_prs1_re, alu_prs2, alu_prs2_re, alu_prd, alu_prd_we, alu_rob_id} =
         {s1, re1, s2, re2, r[12:7], r[13], rob};
      {lsu_prs1, lsu_prs1_re, lsu_prs2, lsu_prs2_re, lsu_prd, lsu_prd_we, lsu_rob_id} =
         {s1, re1, s2, re2, r[12:7], r[13], rob};
      alu_push = ~unit;
      lsu_push = unit;
      if (counted)
      begin
         pushed++;
         sb[int'(rob)] = unit ? {1'b1, 4'd0, lsu_opc, {{20{lsu_imm[11]}}, lsu_imm},
                                 s1, re1, s2, re2, r[12:7], r[13]}
                              : {1'b0, alu_opc, 3'd0, alu_imm,
                                 s1, re1, s2, re2, r[12:7], r[13]};
      end
      @(negedge clk);
      alu_push = 1'b0;
      lsu_push = 1'b0;
   endtask

   task automatic wait_issued(input int cnt);
      int t;
      t = 0;
      while (!aborted && issued.size() < cnt)
      begin
         t++;
         if (t > TMO)
            give_up("issue of the pushed ops");
         @(negedge clk);
      end
   endtask

   // Older op on lane old_unit, younger on the other, both freed together
   task automatic race_lanes(input logic old_unit);
      int k;
      old_id   = next_rob;
      young_id = next_rob + ROB_AW'(1);
      next_rob = next_rob + ROB_AW'(2);
      busytable[20] = 1'b1;
      push_op(~old_unit, young_id, 6'd20, 1'b1, 6'd0, 1'b0, 1'b1);
      push_op(old_unit, old_id, 6'd21, 1'b0, 6'd20, 1'b1, 1'b1);
      k = issued.size();
      busytable[20] = 1'b0;                 // Both lanes ready in one cycle
      wait_issued(pushed);
      assert (issued[k] == old_id)
      else
      begin
         $display("Fail %0t: ROB id %0d left first, older id %0d on lane %0d expected",
                  $time, issued[k], old_id, old_unit);
         errors++;
      end
   endtask

   task automatic report_test(input string name);
      int e;
      e = errors + i_issue_stage.i_assertions.fail_cnt;
      if (e == last_err)
      begin
         $display("Test %s: ok", name);
         passed++;
      end
      else
      begin
         $display("Test %s: failed with %0d errors", name, e - last_err);
         failed++;
      end
      last_err = e;
   endtask

   initial
   begin
      rst = 1'b1;
      {alu_push, alu_imm, alu_prs1, alu_prs1_re, alu_prs2, alu_prs2_re} = '0;
      {alu_prd, alu_prd_we, alu_rob_id} = '0;
      {lsu_push, lsu_imm, lsu_prs1, lsu_prs1_re, lsu_prs2, lsu_prs2_re} = '0;
      {lsu_prd, lsu_prd_we, lsu_rob_id} = '0;
      alu_opc   = ALU_ADD;
      lsu_opc   = LSU_LB;
      busytable = '0;
      ex_ready  = 1'b1;
      next_rob  = '0;
      {pushed, errors, last_err, passed, failed} = '0;
      aborted   = 1'b0;
      repeat (5) @(negedge clk);            // Five reset edges
      rst = 1'b0;

      assert (!ex_valid && alu_ready && lsu_ready)
      else
      begin
         $display("Fail %0t: after reset ex_valid=%b alu_ready=%b lsu_ready=%b", $time,
                  ex_valid, alu_ready, lsu_ready);
         errors++;
      end
      push_op(1'b0, next_rob, 6'd1, 1'b1, 6'd2, 1'b1, 1'b1);
      push_op(1'b1, next_rob + ROB_AW'(1), 6'd3, 1'b1, 6'd4, 1'b0, 1'b1);
      next_rob = next_rob + ROB_AW'(2);
      wait_issued(pushed);
      report_test("1 reset and field match");

      n = issued.size();
      busytable[10] = 1'b1;
      busytable[11] = 1'b1;
      push_op(1'b0, next_rob, 6'd10, 1'b1, 6'd5, 1'b1, 1'b1);
      push_op(1'b1, next_rob + ROB_AW'(1), 6'd6, 1'b0, 6'd11, 1'b1, 1'b1);
      push_op(1'b0, next_rob + ROB_AW'(2), 6'd6, 1'b1, 6'd11, 1'b0, 1'b1); // Busy but unread
      next_rob = next_rob + ROB_AW'(3);
      repeat (8) @(negedge clk);
      assert (issued.size() == n + 1)
      else
      begin
         $display("Fail %0t: %0d ops issued with busy sources pending, expected 1", $time,
                  issued.size() - n);
         errors++;
      end
      busytable = '0;
      wait_issued(pushed);
      report_test("2 busy sources");

      ex_ready = 1'b0;
      n = 0;
      while (alu_ready && n < RS_DEPTH + 2)
      begin
         push_op(1'b0, next_rob, 6'd7, 1'b1, 6'd8, 1'b1, 1'b1);
         next_rob = next_rob + ROB_AW'(1);
         n++;
      end
      assert (n >= RS_DEPTH && n <= RS_DEPTH + 1)
      else
      begin
         $display("Fail %0t: ALU lane took %0d pushes before ready fell", $time, n);
         errors++;
      end
      n = 0;
      while (lsu_ready && n < RS_DEPTH + 2)
      begin
         push_op(1'b1, next_rob, 6'd7, 1'b1, 6'd8, 1'b1, 1'b1);
         next_rob = next_rob + ROB_AW'(1);
         n++;
      end
      assert (n >= RS_DEPTH && n <= RS_DEPTH + 1)
      else
      begin
         $display("Fail %0t: LSU lane took %0d pushes before ready fell", $time, n);
         errors++;
      end
      push_op(1'b0, next_rob, 6'd7, 1'b0, 6'd8, 1'b0, 1'b0);  // Refused push never issues
      push_op(1'b1, next_rob + ROB_AW'(1), 6'd7, 1'b0, 6'd8, 1'b0, 1'b0);
      next_rob = next_rob + ROB_AW'(2);
      repeat (6) @(negedge clk);            // Held outputs under back-pressure
      ex_ready = 1'b1;
      wait_issued(pushed);
      report_test("3 back-pressure and full stations");

      race_lanes(1'b1);                     // Older op in the LSU station
      race_lanes(1'b0);                     // Older op in the ALU station
      report_test("4 age order across lanes");

      old_id   = next_rob;
      young_id = next_rob + ROB_AW'(1);
      busytable[30] = 1'b1;
      busytable[31] = 1'b1;
      push_op(1'b0, old_id, 6'd30, 1'b1, 6'd0, 1'b0, 1'b1);
      push_op(1'b0, young_id, 6'd0, 1'b0, 6'd31, 1'b1, 1'b1);
      n = issued.size();
      busytable[31] = 1'b0;                 // Younger op ready first
      wait_issued(n + 1);
      busytable[30] = 1'b0;
      wait_issued(pushed);
      assert (issued[n] == young_id)
      else
      begin
         $display("Fail %0t: ROB id %0d left first, ready younger id %0d expected", $time,
                  issued[n], young_id);
         errors++;
      end
      old_id   = next_rob + ROB_AW'(2);
      young_id = next_rob + ROB_AW'(3);
      next_rob = next_rob + ROB_AW'(4);
      busytable[30] = 1'b1;
      push_op(1'b0, young_id, 6'd30, 1'b1, 6'd0, 1'b0, 1'b1);  // Younger in the lower slot
      push_op(1'b0, old_id, 6'd0, 1'b0, 6'd30, 1'b1, 1'b1);
      n = issued.size();
      busytable[30] = 1'b0;
      wait_issued(pushed);
      assert (issued[n] == old_id)
      else
      begin
         $display("Fail %0t: ROB id %0d left first, older id %0d expected", $time,
                  issued[n], old_id);
         errors++;
      end
      report_test("5 age order within a station");

      for (int b = 0; b < 5; b++)
      begin
         for (int i = 0; i < 8; i++)
         begin
            rnd       = $random(seed);
            busytable = 64'($random(seed)) & 64'hffff;  // Only low registers get busy
            ex_ready  = rnd[11];
            push_op(rnd[0], next_rob, 6'(rnd[4:1]), rnd[5], 6'(rnd[9:6]), rnd[10], 1'b1);
            next_rob = next_rob + ROB_AW'(1);
         end
         busytable = '0;                    // Drain keeps the ROB id window small
         ex_ready  = 1'b1;
         wait_issued(pushed);
      end
      report_test("6 random stream");

      $display("Summary: %0d tests passed, %0d failed, %0d errors", passed, failed, last_err);
      if (failed == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// ==== issue_stage.f ====
hdl/issue_pkg.sv
hdl/rs_issue_if.sv
hdl/issue_rs.sv
hdl/issue_select.sv
hdl/issue_stage.sv
bench/issue_stage_assertions.sv
bench/issue_stage_tb.sv

// ==== Makefile ====
# Verilator build and run of the issue stage testbench

VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FLIST     ?= issue_stage.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	   echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
